// File: logic/cpu_pkg.sv
package cpu_pkg;

    // datapath widths
    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT = 32;
    localparam int PC_STEP = 4;

    // opcodes, standard mips encoding
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI = 6'h08;
    localparam logic [5:0] OP_LW = 6'h23;
    localparam logic [5:0] OP_SW = 6'h2b;
    localparam logic [5:0] OP_BEQ = 6'h04;

    // funct field of r-type
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef struct packed {
        logic [5:0] op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0] op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0] imm;
    } i_fields_t;

    // one instruction word, viewed as r or i format
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    // sub and add keep their old encodings
    typedef enum logic [3:0] {
        ALU_AND = 4'd0,
        ALU_SUB = 4'd1,
        ALU_ADD = 4'd2,
        ALU_OR = 4'd3,
        ALU_SLT = 4'd4
    } alu_op_t;

    typedef enum logic [1:0] {
        SRC_B_REG = 2'd0,
        SRC_B_STEP = 2'd1,
        SRC_B_IMM = 2'd2,
        SRC_B_IMM_SH = 2'd3
    } src_b_t;

    typedef enum logic [3:0] {
        FETCH, LATCH_IR, DECODE, EXECUTE, WRITE_BACK, EFF_ADDR,
        MEM_READ, LOAD_WB, STORE, BRANCH_ADDR, BRANCH_CMP
    } state_t;

    typedef struct packed {
        logic pc_write;
        logic branch;
        logic pc_src;
        logic ir_write;
        logic rdx_en;
        logic alu_src_a;
        src_b_t alu_src_b;
        alu_op_t alu_op;
        logic alu_out_en;
        logic reg_write;
        logic reg_dst;
        logic mem_to_reg;
        logic i_or_d;
        logic mem_write;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic write;
    } mem_req_t;

endpackage

// File: logic/main_control.sv
`timescale 1ns/1ns

module main_control (
    input logic clk,
    input logic reset,
    input cpu_pkg::instr_t instr,
    output cpu_pkg::ctrl_t ctrl
);
    import cpu_pkg::*;

    state_t state;
    state_t state_next;
    logic is_rtype;
    logic is_addi;
    logic is_lw;
    logic is_sw;
    logic is_beq;
    alu_op_t dec_op;

    // instruction class from the opcode
    assign is_rtype = (instr.r.op == OP_RTYPE);
    assign is_addi = (instr.r.op == OP_ADDI);
    assign is_lw = (instr.r.op == OP_LW);
    assign is_sw = (instr.r.op == OP_SW);
    assign is_beq = (instr.r.op == OP_BEQ);

    // funct decode, only used for r-type
    always_comb
    begin
        case (instr.r.funct)
            FN_ADD: dec_op = ALU_ADD;
            FN_SUB: dec_op = ALU_SUB;
            FN_AND: dec_op = ALU_AND;
            FN_OR: dec_op = ALU_OR;
            FN_SLT: dec_op = ALU_SLT;
            default: dec_op = ALU_ADD;
        endcase
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
            state <= FETCH;
        else
            state <= state_next;
    end

    // one state per clock
    always_comb
    begin
        state_next = FETCH;
        case (state)
            FETCH: state_next = LATCH_IR;
            LATCH_IR: state_next = DECODE;
            DECODE:
            begin
                if (is_rtype || is_addi)
                    state_next = EXECUTE;
                else if (is_lw || is_sw)
                    state_next = EFF_ADDR;
                else if (is_beq)
                    state_next = BRANCH_ADDR;
                // unknown opcode falls back to fetch
            end
            EXECUTE: state_next = WRITE_BACK;
            EFF_ADDR: state_next = is_lw ? MEM_READ : STORE;
            MEM_READ: state_next = LOAD_WB;
            BRANCH_ADDR: state_next = BRANCH_CMP;
            default: state_next = FETCH;
        endcase
    end

    // strobe table, all low unless listed
    always_comb
    begin
        ctrl = '0;
        case (state)
            FETCH:
            begin
                // pc + 4 straight from the alu
                ctrl.pc_write = 1'b1;
                ctrl.alu_src_b = SRC_B_STEP;
                ctrl.alu_op = ALU_ADD;
            end
            LATCH_IR: ctrl.ir_write = 1'b1;
            DECODE: ctrl.rdx_en = 1'b1;
            EXECUTE:
            begin
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_src_b = is_rtype ? SRC_B_REG : SRC_B_IMM;
                ctrl.alu_op = is_rtype ? dec_op : ALU_ADD;
                ctrl.alu_out_en = 1'b1;
            end
            WRITE_BACK:
            begin
                // rd for r-type, rt for addi
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst = is_rtype;
            end
            EFF_ADDR:
            begin
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_src_b = SRC_B_IMM;
                ctrl.alu_op = ALU_ADD;
                ctrl.alu_out_en = 1'b1;
            end
            MEM_READ: ctrl.i_or_d = 1'b1;
            LOAD_WB:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            STORE:
            begin
                ctrl.i_or_d = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            BRANCH_ADDR:
            begin
                // pc already holds pc + 4 here
                ctrl.alu_src_b = SRC_B_IMM_SH;
                ctrl.alu_op = ALU_ADD;
                ctrl.alu_out_en = 1'b1;
            end
            BRANCH_CMP:
            begin
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_src_b = SRC_B_REG;
                ctrl.alu_op = ALU_SUB;
                ctrl.branch = 1'b1;
                ctrl.pc_src = 1'b1;
            end
            default: ctrl = '0;
        endcase
        // every strobe low while reset is held
        if (!reset)
            ctrl = '0;
    end

endmodule

// File: logic/pc_unit.sv
`timescale 1ns/1ns

module pc_unit (
    input logic clk,
    input logic reset,
    input cpu_pkg::ctrl_t ctrl,
    input logic [cpu_pkg::XLEN-1:0] alu_result,
    input logic [cpu_pkg::XLEN-1:0] alu_out,
    input logic zero,
    output logic [cpu_pkg::XLEN-1:0] pc
);
    import cpu_pkg::*;

    logic pc_en;
    logic [XLEN-1:0] pc_next;

    // unconditional write or taken branch
    assign pc_en = ctrl.pc_write | (ctrl.branch & zero);
    // alu_out holds the branch target
    assign pc_next = ctrl.pc_src ? alu_out : alu_result;

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
            pc <= '0;
        else if (pc_en)
            pc <= pc_next;
    end

endmodule

// File: logic/mem_port.sv
`timescale 1ns/1ns

module mem_port (
    input logic clk,
    input logic reset,
    input cpu_pkg::ctrl_t ctrl,
    input logic [cpu_pkg::XLEN-1:0] pc,
    input logic [cpu_pkg::XLEN-1:0] alu_out,
    input logic [cpu_pkg::XLEN-1:0] b_reg,
    input logic [cpu_pkg::XLEN-1:0] mem_rdata,
    output cpu_pkg::mem_req_t mem_req,
    output cpu_pkg::instr_t instr
);
    import cpu_pkg::*;

    // pc for fetch, alu_out for data access
    assign mem_req.addr = ctrl.i_or_d ? alu_out : pc;
    // store data is always register b
    assign mem_req.wdata = b_reg;
    assign mem_req.write = ctrl.mem_write;

    // read data arrives the cycle after fetch
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
            instr <= '0;
        else if (ctrl.ir_write)
            instr <= instr_t'(mem_rdata);
    end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input logic clk,
    input logic reset,
    input cpu_pkg::ctrl_t ctrl,
    input cpu_pkg::instr_t instr,
    input logic [cpu_pkg::XLEN-1:0] alu_out,
    input logic [cpu_pkg::XLEN-1:0] mem_rdata,
    output logic [cpu_pkg::XLEN-1:0] a_reg,
    output logic [cpu_pkg::XLEN-1:0] b_reg
);
    import cpu_pkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [XLEN-1:0] wr_data;
    logic [XLEN-1:0] rd_a;
    logic [XLEN-1:0] rd_b;

    // rd for r-type results, rt for addi and lw
    assign wr_addr = ctrl.reg_dst ? instr.r.rd : instr.r.rt;
    assign wr_data = ctrl.mem_to_reg ? mem_rdata : alu_out;

    // register 0 reads as zero whatever was written
    assign rd_a = (instr.r.rs == '0) ? '0 : regs[instr.r.rs];
    assign rd_b = (instr.r.rt == '0) ? '0 : regs[instr.r.rt];

    always_ff @(posedge clk)
    begin
        if (ctrl.reg_write)
            regs[wr_addr] <= wr_data;
    end

    // operand latches for the execute steps
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            a_reg <= '0;
            b_reg <= '0;
        end
        else if (ctrl.rdx_en)
        begin
            a_reg <= rd_a;
            b_reg <= rd_b;
        end
    end

endmodule

// File: logic/alu_unit.sv
`timescale 1ns/1ns

module alu_unit (
    input logic clk,
    input logic reset,
    input cpu_pkg::ctrl_t ctrl,
    input cpu_pkg::instr_t instr,
    input logic [cpu_pkg::XLEN-1:0] pc,
    input logic [cpu_pkg::XLEN-1:0] a_reg,
    input logic [cpu_pkg::XLEN-1:0] b_reg,
    output logic [cpu_pkg::XLEN-1:0] alu_result,
    output logic [cpu_pkg::XLEN-1:0] alu_out,
    output logic zero
);
    import cpu_pkg::*;

    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;

    // sign extended 16-bit immediate
    assign imm_ext = {{(XLEN-16){instr.i.imm[15]}}, instr.i.imm};
    assign src_a = ctrl.alu_src_a ? a_reg : pc;

    always_comb
    begin
        case (ctrl.alu_src_b)
            SRC_B_REG: src_b = b_reg;
            SRC_B_STEP: src_b = XLEN'(PC_STEP);
            SRC_B_IMM: src_b = imm_ext;
            // word offset for branches
            SRC_B_IMM_SH: src_b = {imm_ext[XLEN-3:0], 2'b00};
            default: src_b = b_reg;
        endcase
    end

    always_comb
    begin
        case (ctrl.alu_op)
            ALU_ADD: alu_result = src_a + src_b;
            ALU_SUB: alu_result = src_a - src_b;
            ALU_AND: alu_result = src_a & src_b;
            ALU_OR: alu_result = src_a | src_b;
            // signed compare
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            default: alu_result = '0;
        endcase
    end

    // beq compares through the subtract
    assign zero = (alu_result == '0);

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
            alu_out <= '0;
        else if (ctrl.alu_out_en)
            alu_out <= alu_result;
    end

endmodule

// File: logic/cpu_top.sv
`timescale 1ns/1ns

module cpu_top (
    input logic clk,
    input logic reset,
    output cpu_pkg::mem_req_t mem_req,
    input logic [cpu_pkg::XLEN-1:0] mem_rdata
);
    import cpu_pkg::*;

    // control strobes to every datapath block
    ctrl_t ctrl;
    // instruction register contents
    instr_t instr;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] a_reg;
    logic [XLEN-1:0] b_reg;
    logic zero;

    main_control i_main_control (
        .clk(clk), .reset(reset), .instr(instr), .ctrl(ctrl)
    );

    pc_unit i_pc_unit (
        .clk(clk), .reset(reset), .ctrl(ctrl), .alu_result(alu_result),
        .alu_out(alu_out), .zero(zero), .pc(pc)
    );

    // address mux, memory request and ir
    mem_port i_mem_port (
        .clk(clk), .reset(reset), .ctrl(ctrl), .pc(pc), .alu_out(alu_out),
        .b_reg(b_reg), .mem_rdata(mem_rdata), .mem_req(mem_req), .instr(instr)
    );

    reg_file i_reg_file (
        .clk(clk), .reset(reset), .ctrl(ctrl), .instr(instr), .alu_out(alu_out),
        .mem_rdata(mem_rdata), .a_reg(a_reg), .b_reg(b_reg)
    );

    alu_unit i_alu_unit (
        .clk(clk), .reset(reset), .ctrl(ctrl), .instr(instr), .pc(pc),
        .a_reg(a_reg), .b_reg(b_reg), .alu_result(alu_result),
        .alu_out(alu_out), .zero(zero)
    );

endmodule

// File: tests/cpu_chk.sv
`timescale 1ns/1ns

module cpu_chk (
    input logic clk,
    input logic reset,
    input cpu_pkg::state_t state,
    input cpu_pkg::ctrl_t ctrl
);
    import cpu_pkg::*;

    // stores only leave the core from the STORE state
    assert property (@(posedge clk) disable iff (!reset) ctrl.mem_write |-> state == STORE)
        else $error("mem_write raised outside the STORE state");

    // ir load and register write never share a cycle
    assert property (@(posedge clk) disable iff (!reset) !(ctrl.ir_write && ctrl.reg_write))
        else $error("ir_write and reg_write high in the same cycle");

    // first cycle out of reset is a fetch
    assert property (@(posedge clk) $rose(reset) |-> state == FETCH)
        else $error("state after reset release is not FETCH");

endmodule

bind main_control cpu_chk i_cpu_chk (
    .clk(clk), .reset(reset), .state(state), .ctrl(ctrl)
);

// File: tests/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb;
    import cpu_pkg::*;

    localparam int MEM_AW = 8;
    localparam int MEM_WORDS = 1 << MEM_AW;
    localparam int VEC_WORDS = 128;
    localparam int MAX_STORES = 32;
    localparam int STORE_TIMEOUT = 1000;
    localparam int TAIL_CYCLES = 40;

    logic clk;
    logic reset;
    logic [XLEN-1:0] mem_rdata = '0;
    mem_req_t mem_req;

    // unified program and data memory, word addressed
    logic [XLEN-1:0] mem [MEM_WORDS];
    // raw words from the vector file
    logic [XLEN-1:0] vectors [VEC_WORDS];
    // expected store sequence
    logic [XLEN-1:0] exp_addr [MAX_STORES];
    logic [XLEN-1:0] exp_data [MAX_STORES];
    int prog_len;
    int store_count;
    int stores_seen = 0;

    cpu_top i_cpu_top (
        .clk(clk),
        .reset(reset),
        .mem_req(mem_req),
        .mem_rdata(mem_rdata)
    );

    // 4 ns clock
    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare(input string name, input logic [XLEN-1:0] actual,
                           input logic [XLEN-1:0] expected);
        if (actual !== expected)
            fail_run($sformatf("[ERROR] %0t %s got %h expected %h",
                               $time, name, actual, expected));
    endtask

    // filler for words never written, distinct per address
    function automatic logic [XLEN-1:0] fill_word(input int idx);
        return 32'ha5000000 | XLEN'(idx * 4);
    endfunction

    // length, program, store count, then address/data pairs
    task automatic load_vectors();
        int i;
        $readmemh("tests/cpu_vectors.hex", vectors);
        prog_len = int'(vectors[0]);
        if (prog_len < 1 || prog_len > MEM_WORDS)
            fail_run("vector file missing or program length out of range");
        store_count = int'(vectors[prog_len + 1]);
        if (store_count < 1 || store_count > MAX_STORES)
            fail_run("store count in the vector file out of range");
        for (i = 0; i < MEM_WORDS; i++)
            mem[i] = fill_word(i);
        // program sits at address 0
        for (i = 0; i < prog_len; i++)
            mem[i] = vectors[i + 1];
        for (i = 0; i < store_count; i++)
        begin
            exp_addr[i] = vectors[prog_len + 2 + 2 * i];
            exp_data[i] = vectors[prog_len + 3 + 2 * i];
        end
    endtask

    task automatic check_store();
        if (!reset)
            fail_run("write strobe seen while reset is asserted");
        else if (stores_seen >= store_count)
            fail_run($sformatf("unexpected extra store to address %h", mem_req.addr));
        else
        begin
            compare("mem_req.addr", mem_req.addr, exp_addr[stores_seen]);
            compare("mem_req.wdata", mem_req.wdata, exp_data[stores_seen]);
            stores_seen++;
        end
    endtask

    task automatic wait_for_stores();
        int cycles;
        cycles = 0;
        while (stores_seen < store_count && cycles < STORE_TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (stores_seen < store_count)
            fail_run($sformatf("timeout after %0d cycles, only %0d of %0d stores seen",
                               cycles, stores_seen, store_count));
    endtask

    // read data one cycle after the address, write on the strobe
    always @(posedge clk)
    begin
        mem_rdata <= mem[mem_req.addr[MEM_AW+1:2]];
        if (mem_req.write)
            mem[mem_req.addr[MEM_AW+1:2]] = mem_req.wdata;
    end

    // request is settled by the falling edge
    always @(negedge clk)
    begin
        if (mem_req.write)
            check_store();
    end

    initial
    begin
        reset <= 1'b0;
        load_vectors();
        repeat (16)
            @(posedge clk);
        reset <= 1'b1;
        // first fetch comes from address 0
        @(negedge clk);
        compare("mem_req.addr", mem_req.addr, '0);
        wait_for_stores();
        // program ends in a self loop, any further write stops the run
        repeat (TAIL_CYCLES)
            @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

// File: sources.f
logic/cpu_pkg.sv
logic/main_control.sv
logic/pc_unit.sv
logic/mem_port.sv
logic/reg_file.sv
logic/alu_unit.sv
logic/cpu_top.sv
tests/cpu_chk.sv
tests/cpu_tb.sv

// File: Makefile
TOP = cpu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "sim failed" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "sim passed" sim.log || { echo "no pass verdict in sim.log"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// File: tests/cpu_vectors.hex
// word 0 is the program length P, then P program words placed from address 0
// then the store count S, then S lines of store address and store data
00000017
// addi r1 = 7, addi r2 = -3, then add/sub/and/or/slt each stored from 0x100 up
20010007 2002fffd 00221820 ac030100
00412022 ac040104 00222824 ac050108
00223025 ac06010c 0041382a ac070110
// addi with negative immediate, sw then lw of the same word, sw of the load
2028ffec ac080114 8c090114 ac090118
// taken beq skips the store of r1, untaken beq keeps the store of r2
10210001 ac01011c 10220001 ac020120
// add into r0 then store r0, last word is beq r0, r0 back onto itself
00210020 ac000124 1000ffff
00000009
00000100 00000004
00000104 fffffff6
00000108 00000005
0000010c ffffffff
00000110 00000001
00000114 fffffff3
00000118 fffffff3
00000120 fffffffd
00000124 00000000
